// File: design/board_input_top.sv
/*
 * board input top level
 * serial reader, frame latch and input mapper for two pads and board keys
 */
`timescale 1ns/1ps
`default_nettype none

module board_input_top (
    input  logic                               clk_sys,
    input  logic                               game_rst,
    // serial pad chain
    output logic                               joy_clk,
    output logic                               joy_load,
    input  logic                               joy_data,
    // board keys
    input  logic                               key_pause,
    input  logic                               key_reset,
    input  logic                               key_service,
    input  logic [board_pkg::gfx_layers-1:0]   key_gfx,
    input  logic                               rot,
    // game side, active low
    output logic [board_pkg::joy_out_w-1:0]    game_joystick1,
    output logic [board_pkg::joy_out_w-1:0]    game_joystick2,
    output logic [1:0]                         game_coin,
    output logic [1:0]                         game_start,
    output logic                               game_service,
    output logic                               game_pause,
    output logic                               soft_rst,
    output logic [board_pkg::gfx_layers-1:0]   gfx_en
);

    joy_pkg::pad_t pad1;
    joy_pkg::pad_t pad2;

    joy_sample_if smp_if ();

    joy_serial_reader u_reader (
        .clk_sys  (clk_sys),
        .game_rst (game_rst),
        .joy_data (joy_data),
        .joy_clk  (joy_clk),
        .joy_load (joy_load),
        .smp      (smp_if.reader)
    );

    joy_frame_latch u_latch (
        .clk_sys  (clk_sys),
        .game_rst (game_rst),
        .smp      (smp_if.latch),
        .pad1     (pad1),
        .pad2     (pad2)
    );

    input_mapper u_mapper (
        .clk_sys        (clk_sys),
        .game_rst       (game_rst),
        .pad1           (pad1),
        .pad2           (pad2),
        .key_pause      (key_pause),
        .key_reset      (key_reset),
        .key_service    (key_service),
        .key_gfx        (key_gfx),
        .rot            (rot),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service),
        .game_pause     (game_pause),
        .soft_rst       (soft_rst),
        .gfx_en         (gfx_en)
    );

endmodule

`default_nettype wire

// File: design/board_pkg.sv
/*
 * game side input definitions
 * output polarity, joystick width and graphics layer count
 */
`default_nettype none

package board_pkg;

    localparam logic inputs_active_low = 1'b1;     // game expects 0 = pressed

    localparam int joy_out_w  = 7;                 // 4 directions + 3 fires
    localparam int gfx_layers = 4;

    // xor masks, also the released value of each output
    localparam logic [joy_out_w-1:0] joy_pol_mask = {joy_out_w{inputs_active_low}};
    localparam logic [1:0] pair_pol_mask = {2{inputs_active_low}};

endpackage

`default_nettype wire

// File: design/input_mapper.sv
/*
 * game input mapper
 * turns the latched pads and board keys into active-low game inputs,
 * with direction rotation, pause and layer toggles and a soft reset pulse
 */
`timescale 1ns/1ps
`default_nettype none

module input_mapper (
    input  logic                               clk_sys,
    input  logic                               game_rst,
    input  joy_pkg::pad_t                      pad1,
    input  joy_pkg::pad_t                      pad2,
    input  logic                               key_pause,
    input  logic                               key_reset,
    input  logic                               key_service,
    input  logic [board_pkg::gfx_layers-1:0]   key_gfx,
    input  logic                               rot,
    output logic [board_pkg::joy_out_w-1:0]    game_joystick1,
    output logic [board_pkg::joy_out_w-1:0]    game_joystick2,
    output logic [1:0]                         game_coin,
    output logic [1:0]                         game_start,
    output logic                               game_service,
    output logic                               game_pause,
    output logic                               soft_rst,
    output logic [board_pkg::gfx_layers-1:0]   gfx_en
);

    logic                             last_key_pause;
    logic                             last_joy_pause;
    logic                             last_key_reset;
    logic [board_pkg::gfx_layers-1:0] last_gfx;
    logic                             joy_pause;
    logic                             pause_rise;
    logic [board_pkg::gfx_layers-1:0] gfx_rise;

    // fires on top, directions below, polarity applied
    function automatic logic [board_pkg::joy_out_w-1:0] map_joy(
        input joy_pkg::pad_t pad,
        input logic          rotate
    );
        logic [3:0] dir;
        if (rotate) begin
            dir = {pad[joy_pkg::pad_right], pad[joy_pkg::pad_left],
                   pad[joy_pkg::pad_up], pad[joy_pkg::pad_down]};
        end else begin
            dir = {pad[joy_pkg::pad_up], pad[joy_pkg::pad_down],
                   pad[joy_pkg::pad_left], pad[joy_pkg::pad_right]};
        end
        return board_pkg::joy_pol_mask ^ {pad[joy_pkg::pad_fire3], pad[joy_pkg::pad_fire2],
                                          pad[joy_pkg::pad_fire1], dir};
    endfunction

    assign joy_pause  = pad1[joy_pkg::pad_pause] | pad2[joy_pkg::pad_pause];
    assign pause_rise = (key_pause && !last_key_pause) || (joy_pause && !last_joy_pause);
    assign gfx_rise   = key_gfx & ~last_gfx;

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            last_key_pause <= 1'b0;
            last_joy_pause <= 1'b0;
            last_key_reset <= 1'b0;
            last_gfx       <= '0;
            game_joystick1 <= board_pkg::joy_pol_mask;     // released
            game_joystick2 <= board_pkg::joy_pol_mask;
            game_coin      <= board_pkg::pair_pol_mask;
            game_start     <= board_pkg::pair_pol_mask;
            game_service   <= board_pkg::inputs_active_low;
            game_pause     <= 1'b0;
            soft_rst       <= 1'b0;
            gfx_en         <= '1;                          // all layers on
        end else begin
            last_key_pause <= key_pause;
            last_joy_pause <= joy_pause;
            last_key_reset <= key_reset;
            last_gfx       <= key_gfx;

            game_joystick1 <= map_joy(pad1, rot);
            game_joystick2 <= map_joy(pad2, rot);
            game_coin      <= board_pkg::pair_pol_mask ^
                              {pad2[joy_pkg::pad_coin], pad1[joy_pkg::pad_coin]};
            game_start     <= board_pkg::pair_pol_mask ^
                              {pad2[joy_pkg::pad_start], pad1[joy_pkg::pad_start]};
            game_service   <= key_service ^ board_pkg::inputs_active_low;

            if (pause_rise) begin
                game_pause <= ~game_pause;
            end
            soft_rst <= key_reset && !last_key_reset;   // single cycle pulse
            gfx_en   <= gfx_en ^ gfx_rise;
        end
    end

    a_soft_rst_pulse: assert property (
        @(posedge clk_sys) disable iff (game_rst)
        soft_rst |=> !soft_rst
    );

endmodule

`default_nettype wire

// File: design/joy_frame_latch.sv
/*
 * joystick frame latch
 * builds both pads from the slot samples in shadow registers and
 * publishes them together once the last slot of a frame is in
 */
`timescale 1ns/1ps
`default_nettype none

module joy_frame_latch (
    input  logic          clk_sys,
    input  logic          game_rst,
    joy_sample_if.latch   smp,
    output joy_pkg::pad_t pad1,
    output joy_pkg::pad_t pad2
);

    joy_pkg::pad_t      shadow1;
    joy_pkg::pad_t      shadow2;
    joy_pkg::pad_t      sh1_nxt;
    joy_pkg::pad_t      sh2_nxt;
    joy_pkg::joy_slot_t rel_p1;
    joy_pkg::joy_slot_t rel_p2;
    joy_pkg::joy_slot_t rel_tail;
    logic               publish;

    // offsets wrap for earlier slots, so one compare bounds each group
    assign rel_p1   = smp.slot - joy_pkg::first_p1_slot;
    assign rel_p2   = smp.slot - joy_pkg::first_p2_slot;
    assign rel_tail = smp.slot - joy_pkg::first_tail_slot;

    assign publish = smp.sample_stb && smp.frame_end;

    always_comb begin
        sh1_nxt = shadow1;
        sh2_nxt = shadow2;
        if (smp.sample_stb) begin
            if (rel_p1 < joy_pkg::pad_group_len) begin
                sh1_nxt[joy_pkg::group_bit[rel_p1[2:0]]] = smp.bit_val;
            end else if (rel_p2 < joy_pkg::pad_group_len) begin
                sh2_nxt[joy_pkg::group_bit[rel_p2[2:0]]] = smp.bit_val;
            end else if (rel_tail < joy_pkg::pad_group_len) begin
                // upper half of the tail is p1
                if (rel_tail[2]) begin
                    sh1_nxt[joy_pkg::tail_bit[rel_tail[1:0]]] = smp.bit_val;
                end else begin
                    sh2_nxt[joy_pkg::tail_bit[rel_tail[1:0]]] = smp.bit_val;
                end
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            shadow1 <= joy_pkg::pad_released;
            shadow2 <= joy_pkg::pad_released;
            pad1    <= joy_pkg::pad_released;
            pad2    <= joy_pkg::pad_released;
        end else if (publish) begin
            pad1    <= sh1_nxt;                    // includes the last slot's bit
            pad2    <= sh2_nxt;
            shadow1 <= joy_pkg::pad_released;      // fresh frame
            shadow2 <= joy_pkg::pad_released;
        end else begin
            shadow1 <= sh1_nxt;
            shadow2 <= sh2_nxt;
        end
    end

    a_publish_at_frame_end: assert property (
        @(posedge clk_sys) disable iff (game_rst)
        ((pad1 != $past(pad1)) || (pad2 != $past(pad2))) |-> $past(publish)
    );

endmodule

`default_nettype wire

// File: design/joy_pkg.sv
/*
 * serial joystick protocol definitions
 * frame length, joy_clk timing, pad bit layout and the slot map
 * shared by the serial reader and the frame latch
 */
`default_nettype none

package joy_pkg;

    localparam int joy_slot_count = 26;            // slots per serial frame
    typedef logic [4:0] joy_slot_t;
    localparam joy_slot_t joy_last_slot = joy_slot_t'(joy_slot_count - 1);

    // clk_sys cycles per joy_clk half period
    localparam int joy_clk_half = 8;
    localparam int joy_half_w = $clog2(joy_clk_half);
    typedef logic [joy_half_w-1:0] joy_half_t;
    localparam joy_half_t joy_half_last = joy_half_t'(joy_clk_half - 1);

    typedef logic [11:0] pad_t;                    // 1 = pressed
    typedef logic [3:0] pad_bit_t;

    localparam pad_bit_t pad_right   = 4'd0;
    localparam pad_bit_t pad_left    = 4'd1;
    localparam pad_bit_t pad_down    = 4'd2;
    localparam pad_bit_t pad_up      = 4'd3;
    localparam pad_bit_t pad_fire1   = 4'd4;
    localparam pad_bit_t pad_fire2   = 4'd5;
    localparam pad_bit_t pad_fire3   = 4'd6;
    localparam pad_bit_t pad_spare7  = 4'd7;
    localparam pad_bit_t pad_start   = 4'd8;
    localparam pad_bit_t pad_coin    = 4'd9;
    localparam pad_bit_t pad_spare10 = 4'd10;
    localparam pad_bit_t pad_pause   = 4'd11;

    localparam pad_t pad_released = '0;

    // slots 2-9 p1 and 10-17 p2 share one order, then an 8-slot tail
    localparam joy_slot_t first_p1_slot   = 5'd2;
    localparam joy_slot_t first_p2_slot   = 5'd10;
    localparam joy_slot_t first_tail_slot = 5'd18;
    localparam joy_slot_t pad_group_len   = 5'd8;

    localparam pad_bit_t group_bit [8] = '{
        pad_start, pad_fire3, pad_fire2, pad_fire1,
        pad_right, pad_left, pad_down, pad_up
    };

    // tail order, first four slots for p2 then four for p1
    localparam pad_bit_t tail_bit [4] = '{pad_spare10, pad_pause, pad_coin, pad_spare7};

endpackage

`default_nettype wire

// File: design/joy_sample_if.sv
/*
 * serial sample link
 * carries each strobed joystick bit and its slot from the reader to the latch
 */
`timescale 1ns/1ps
`default_nettype none

interface joy_sample_if;

    logic               sample_stb;   // one cycle, joy_clk rise
    joy_pkg::joy_slot_t slot;         // slot the bit belongs to
    logic               bit_val;      // 1 = pressed
    logic               frame_end;    // with sample_stb on the last slot

    modport reader (
        output sample_stb,
        output slot,
        output bit_val,
        output frame_end
    );

    modport latch (
        input sample_stb,
        input slot,
        input bit_val,
        input frame_end
    );

endinterface

`default_nettype wire

// File: design/joy_serial_reader.sv
/*
 * serial joystick reader
 * divides clk_sys down to joy_clk as a clock enable, frames the
 * shift chain with joy_load and samples joy_data once per slot
 */
`timescale 1ns/1ps
`default_nettype none

module joy_serial_reader (
    input  logic         clk_sys,
    input  logic         game_rst,
    input  logic         joy_data,
    output logic         joy_clk,
    output logic         joy_load,
    joy_sample_if.reader smp
);

    joy_pkg::joy_half_t half_cnt;
    logic               half_done;
    logic               clk_rise;

    assign half_done = (half_cnt == joy_pkg::joy_half_last);
    assign clk_rise  = half_done && !joy_clk;      // joy_clk goes high next cycle

    // chain loads while slot 0 is active
    assign joy_load = (smp.slot != '0);

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            half_cnt       <= '0;
            joy_clk        <= 1'b0;
            smp.slot       <= '0;
            smp.sample_stb <= 1'b0;
            smp.frame_end  <= 1'b0;
        end else begin
            half_cnt <= half_done ? '0 : half_cnt + 1'b1;
            if (half_done) begin
                joy_clk <= ~joy_clk;
            end
            smp.sample_stb <= clk_rise;
            smp.frame_end  <= clk_rise && (smp.slot == joy_pkg::joy_last_slot);
            // slot moves on once its strobe has gone out
            if (smp.sample_stb) begin
                if (smp.slot == joy_pkg::joy_last_slot) begin
                    smp.slot <= '0;
                end else begin
                    smp.slot <= smp.slot + 1'b1;
                end
            end
        end
    end

    // data bit, captured as joy_clk rises
    always_ff @(posedge clk_sys) begin
        if (clk_rise) begin
            smp.bit_val <= ~joy_data;                  // pads pull low when pressed
        end
    end

    a_slot_range: assert property (
        @(posedge clk_sys) disable iff (game_rst)
        smp.slot <= joy_pkg::joy_last_slot
    );

    a_stb_spaced: assert property (
        @(posedge clk_sys) disable iff (game_rst)
        smp.sample_stb |=> !smp.sample_stb
    );

endmodule

`default_nettype wire

// File: dv/board_input_tb.sv
/*
 * board input testbench
 * directed tests for reset state, pad mapping, rotation,
 * pause, soft reset, layer toggles and service key
 */
`timescale 1ns/1ps
`default_nettype none

module board_input_tb;

    localparam int clk_period    = 40;
    localparam int frame_cycles  = joy_pkg::joy_slot_count * 2 * joy_pkg::joy_clk_half;
    localparam int settle_cycles = 2 * frame_cycles;        // two full frames
    localparam int test_frames   = 40;
    localparam int watchdog_ns   = 2 * test_frames * frame_cycles * clk_period;

    logic          clk_sys = 1'b0;
    logic          game_rst;
    logic          joy_clk;
    logic          joy_load;
    logic          joy_data;
    logic          key_pause;
    logic          key_reset;
    logic          key_service;
    logic [3:0]    key_gfx;
    logic          rot;
    logic [6:0]    game_joystick1;
    logic [6:0]    game_joystick2;
    logic [1:0]    game_coin;
    logic [1:0]    game_start;
    logic          game_service;
    logic          game_pause;
    logic          soft_rst;
    logic [3:0]    gfx_en;
    joy_pkg::pad_t pad1_pat;
    joy_pkg::pad_t pad2_pat;
    int            errors = 0;
    integer        seed = 32'h9455;

    always #(clk_period / 2) clk_sys = ~clk_sys;

    board_input_top DUT (.*);

    joy_pad_model u_pads (
        .clk_sys  (clk_sys),
        .joy_clk  (joy_clk),
        .joy_load (joy_load),
        .pad1     (pad1_pat),
        .pad2     (pad2_pat),
        .joy_data (joy_data)
    );

    // directions and fires, rotated when asked, then polarity
    function automatic logic [6:0] expect_joy(input joy_pkg::pad_t pad, input logic rotated);
        logic [6:0] pressed;
        pressed = pad[6:0];
        if (rotated) begin
            pressed[3] = pad[0];
            pressed[2] = pad[1];
            pressed[1] = pad[3];
            pressed[0] = pad[2];
        end
        return board_pkg::inputs_active_low ? ~pressed : pressed;
    endfunction

    function automatic logic [1:0] expect_pair(input logic p2_bit, input logic p1_bit);
        return board_pkg::inputs_active_low ? ~{p2_bit, p1_bit} : {p2_bit, p1_bit};
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("FAILED %s: expected %h, actual %h", test, exp, act);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_sys);
    endtask

    task automatic apply_pads(input joy_pkg::pad_t p1, input joy_pkg::pad_t p2);
        @(negedge clk_sys);
        pad1_pat = p1;
        pad2_pat = p2;
        wait_cycles(settle_cycles);
    endtask

    task automatic test_reset_state();
        if (game_joystick1 !== 7'h7f)
            report_mismatch("reset joystick1", 32'h7f, 32'(game_joystick1));
        if (game_joystick2 !== 7'h7f)
            report_mismatch("reset joystick2", 32'h7f, 32'(game_joystick2));
        if (game_coin !== 2'b11) report_mismatch("reset coin", 32'h3, 32'(game_coin));
        if (game_start !== 2'b11) report_mismatch("reset start", 32'h3, 32'(game_start));
        if (game_service !== 1'b1) report_mismatch("reset service", 32'h1, 32'(game_service));
        if (game_pause !== 1'b0) report_mismatch("reset pause", 32'h0, 32'(game_pause));
        if (soft_rst !== 1'b0) report_mismatch("reset soft_rst", 32'h0, 32'(soft_rst));
        if (gfx_en !== 4'hf) report_mismatch("reset gfx_en", 32'hf, 32'(gfx_en));
        if (joy_clk !== 1'b0) report_mismatch("reset joy_clk", 32'h0, 32'(joy_clk));
        if (joy_load !== 1'b0) report_mismatch("reset joy_load", 32'h0, 32'(joy_load));
    endtask

    task automatic test_random_pads();
        joy_pkg::pad_t p1;
        joy_pkg::pad_t p2;
        logic [31:0]   rnd;
        logic [6:0]    exp_joy;
        logic [1:0]    exp_pair;
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            p1  = rnd[11:0] & 12'h7ff;                  // pause bit kept clear
            p2  = rnd[27:16] & 12'h7ff;
            apply_pads(p1, p2);
            exp_joy = expect_joy(p1, 1'b0);
            if (game_joystick1 !== exp_joy)
                report_mismatch("random joystick1", 32'(exp_joy), 32'(game_joystick1));
            exp_joy = expect_joy(p2, 1'b0);
            if (game_joystick2 !== exp_joy)
                report_mismatch("random joystick2", 32'(exp_joy), 32'(game_joystick2));
            exp_pair = expect_pair(p2[9], p1[9]);
            if (game_coin !== exp_pair)
                report_mismatch("random coin", 32'(exp_pair), 32'(game_coin));
            exp_pair = expect_pair(p2[8], p1[8]);
            if (game_start !== exp_pair)
                report_mismatch("random start", 32'(exp_pair), 32'(game_start));
        end
    endtask

    task automatic test_rotation();
        joy_pkg::pad_t p;
        logic [6:0]    exp_joy;
        @(negedge clk_sys);
        rot = 1'b1;
        for (int d = 0; d < 4; d++) begin
            p = 12'h050 | (12'h001 << d);               // fire1 and fire3 held too
            apply_pads(p, joy_pkg::pad_released);
            exp_joy = expect_joy(p, 1'b1);
            if (game_joystick1 !== exp_joy)
                report_mismatch("rotation joystick1", 32'(exp_joy), 32'(game_joystick1));
        end
        rot = 1'b0;
        apply_pads(joy_pkg::pad_released, joy_pkg::pad_released);
    endtask

    task automatic test_pause();
        @(negedge clk_sys);
        key_pause = 1'b1;
        wait_cycles(6);                                 // held, one toggle only
        if (game_pause !== 1'b1) report_mismatch("pause key held", 32'h1, 32'(game_pause));
        key_pause = 1'b0;
        wait_cycles(4);
        if (game_pause !== 1'b1) report_mismatch("pause key released", 32'h1, 32'(game_pause));
        apply_pads(joy_pkg::pad_released, 12'h800);
        if (game_pause !== 1'b0) report_mismatch("pause p2 pressed", 32'h0, 32'(game_pause));
        wait_cycles(frame_cycles);
        if (game_pause !== 1'b0) report_mismatch("pause p2 held", 32'h0, 32'(game_pause));
        apply_pads(joy_pkg::pad_released, joy_pkg::pad_released);
        if (game_pause !== 1'b0) report_mismatch("pause p2 released", 32'h0, 32'(game_pause));
    endtask

    task automatic test_soft_reset();
        int pulses;
        pulses = 0;
        @(negedge clk_sys);
        key_reset = 1'b1;
        repeat (20) begin
            @(negedge clk_sys);
            if (soft_rst === 1'b1) pulses++;
        end
        key_reset = 1'b0;
        if (pulses != 1) report_mismatch("soft_reset cycles", 32'd1, 32'(pulses));
    endtask

    task automatic test_gfx_and_service();
        logic [3:0] exp_gfx;
        exp_gfx = 4'hf;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk_sys);
            key_gfx = 4'b0001 << i;
            wait_cycles(3);
            key_gfx = '0;
            wait_cycles(2);
            exp_gfx = exp_gfx ^ (4'b0001 << i);
            if (gfx_en !== exp_gfx) report_mismatch("gfx toggle", 32'(exp_gfx), 32'(gfx_en));
        end
        key_service = 1'b1;
        @(negedge clk_sys);                             // one register stage
        if (game_service !== 1'b0) report_mismatch("service pressed", 32'h0, 32'(game_service));
        key_service = 1'b0;
        @(negedge clk_sys);
        if (game_service !== 1'b1) report_mismatch("service released", 32'h1, 32'(game_service));
    endtask

    initial begin
        game_rst    = 1'b1;
        key_pause   = 1'b0;
        key_reset   = 1'b0;
        key_service = 1'b0;
        key_gfx     = '0;
        rot         = 1'b0;
        pad1_pat    = joy_pkg::pad_released;
        pad2_pat    = joy_pkg::pad_released;
        repeat (10) @(negedge clk_sys);
        game_rst = 1'b0;
        @(negedge clk_sys);
        test_reset_state();
        test_random_pads();
        test_rotation();
        test_pause();
        test_soft_reset();
        test_gfx_and_service();
        $display("tests done, %0d error(s)", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // stops a run that never reaches the end of the tests
    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, tests did not finish, %0d error(s)",
                 watchdog_ns, errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/joy_pad_model.sv
/*
 * two-pad serial chain model
 * reloads on joy_load low, shifts on each joy_clk rise and drives
 * the active-low bit of the current slot on joy_data
 */
`timescale 1ns/1ps
`default_nettype none

module joy_pad_model (
    input  logic          clk_sys,
    input  logic          joy_clk,
    input  logic          joy_load,
    input  joy_pkg::pad_t pad1,     // 1 = pressed
    input  joy_pkg::pad_t pad2,
    output logic          joy_data
);

    int   slot = 0;
    logic last_clk = 1'b0;

    // start, fire3, fire2, fire1, right, left, down, up
    function automatic logic pick_group(input joy_pkg::pad_t pad, input int k);
        case (k)
            0:       return pad[8];
            1:       return pad[6];
            2:       return pad[5];
            3:       return pad[4];
            4:       return pad[0];
            5:       return pad[1];
            6:       return pad[2];
            default: return pad[3];
        endcase
    endfunction

    // bit10, pause, coin, bit7
    function automatic logic pick_tail(input joy_pkg::pad_t pad, input int k);
        case (k)
            0:       return pad[10];
            1:       return pad[11];
            2:       return pad[9];
            default: return pad[7];
        endcase
    endfunction

    function automatic logic slot_pressed(input int s, input joy_pkg::pad_t a,
                                          input joy_pkg::pad_t b);
        if (s >= 2 && s <= 9) return pick_group(a, s - 2);
        if (s >= 10 && s <= 17) return pick_group(b, s - 10);
        if (s >= 18 && s <= 21) return pick_tail(b, s - 18);
        if (s >= 22 && s <= 25) return pick_tail(a, s - 22);
        return 1'b0;                                    // slots 0, 1 unused
    endfunction

    always @(negedge clk_sys) begin
        if (joy_clk === 1'b1 && last_clk === 1'b0) begin
            slot = (joy_load === 1'b1) ? slot + 1 : 1;  // rise ends the slot
        end else if (joy_load !== 1'b1) begin
            slot = 0;                                   // parallel load
        end
        last_clk = joy_clk;
        joy_data = ~slot_pressed(slot, pad1, pad2);
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the board input testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
    --top-module board_input_tb -Mdir obj_dir -o board_input_sim > build.log 2>&1 \
    && ./obj_dir/board_input_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: vlog.f
design/joy_pkg.sv
design/board_pkg.sv
design/joy_sample_if.sv
design/joy_serial_reader.sv
design/joy_frame_latch.sv
design/input_mapper.sv
design/board_input_top.sv
dv/joy_pad_model.sv
dv/board_input_tb.sv
